// ==== project.f ====
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
execute/exeStageReg.sv
execute/operandBypass.sv
execute/aluCore.sv
execute/multDivUnit.sv
execute/exeResult.sv
hdl/exeTop.sv
verification/exeTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = exeTb
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== verification/exeTb.sv ====
// needs common/ on the include path; operands come from a fixed-seed LFSR, run stops at first error
`include "exe_config.svh"

module exeTb import isaPkg::*, pipePkg::*; ();

    typedef struct packed {
        idExeS              id;
        bypassS             mb;
        bypassS             wb;
        logic               flush;      // row is loaded under exeFlush
        logic [`DATA_W-1:0] expAlu;
        exceptE             expExc;
        logic [3:0]         expWen;
        logic               expBr;
        logic               expRegWr;
    } vecS;

    logic               clk;
    logic               rstN;
    logic               exeWr;
    logic               exeFlush;
    logic               hiLoFlush;
    idExeS              idExe;
    bypassS             memBypass;
    bypassS             wbBypass;
    exeMemS             exeMem;
    logic               branchFlush;
    logic               mdStall;
    logic               mdFinish;
    logic [`DATA_W-1:0] mdHi;
    logic [`DATA_W-1:0] mdLo;

    vecS                vectors[$];
    string              names[$];
    logic [31:0]        lfsr = 32'h97cfea93;

    exeTop exeTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopRun(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkEq(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
            stopRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    // galois form, taps 32 22 2 1
    function automatic logic stepBit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [31:0] randWord();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], stepBit()};
        return w;
    endfunction

    // reference results, shift amount from a[4:0]
    function automatic logic [31:0] refAlu(aluOpE op, logic [31:0] a, logic [31:0] b);
        case (op)
            ALU_ADD, ALU_ADDU: return a + b;
            ALU_SUB, ALU_SUBU: return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return b << a[4:0];
            ALU_SRL:  return b >> a[4:0];
            ALU_SRA:  return $signed(b) >>> a[4:0];
            ALU_LUI:  return {b[15:0], 16'h0000};
            default:  return 32'h0;
        endcase
    endfunction

    // overflow when the wide result does not fit in 32 signed bits
    function automatic logic refOverflow(aluOpE op, logic [31:0] a, logic [31:0] b);
        longint r;
        if (op == ALU_ADD)
            r = longint'($signed(a)) + longint'($signed(b));
        else if (op == ALU_SUB)
            r = longint'($signed(a)) - longint'($signed(b));
        else
            return 1'b0;
        return r != longint'($signed(r[31:0]));
    endfunction

    // {hi, lo}; divide gives remainder in hi
    function automatic logic [63:0] refMd(aluOpE op, logic [31:0] a, logic [31:0] b);
        longint sa;
        longint sb;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            ALU_MULT:  return sa * sb;
            ALU_MULTU: return {32'h0, a} * {32'h0, b};
            ALU_DIV:   return (b == 0) ? 64'h0 : {32'(sa % sb), 32'(sa / sb)};
            default:   return (b == 0) ? 64'h0 : {a % b, a / b};
        endcase
    endfunction

    // rt after bypassing, MEM before WB, gpr 0 never forwarded
    function automatic logic [31:0] refStoreData(vecS v);
        if (v.id.readsRt && v.mb.regWr && v.mb.dst == v.id.rt && v.id.rt != 5'd0)
            return v.mb.result;
        if (v.id.readsRt && v.wb.regWr && v.wb.dst == v.id.rt && v.id.rt != 5'd0)
            return v.wb.result;
        return v.id.busB;
    endfunction

    function automatic logic [4:0] refDst(idExeS id);
        case (id.dstSel)
            DST_RT:  return id.rt;
            DST_RA:  return 5'd31;
            default: return id.rd;
        endcase
    endfunction

    function automatic idExeS baseRow(aluOpE op, logic [31:0] a, logic [31:0] b);
        idExeS r;
        r = '0;
        r.busA = a;
        r.busB = b;
        r.pc = randWord();
        r.rs = 5'd1;
        r.rt = 5'd2;
        r.rd = 5'd3;
        r.aluOp = op;
        r.readsRs = 1'b1;
        r.readsRt = 1'b1;
        r.regWr = 1'b1;
        return r;
    endfunction

    task automatic addRow(string name, idExeS id, bypassS mb, bypassS wb, logic flush,
                          logic [31:0] expAlu, exceptE expExc, logic [3:0] expWen,
                          logic expBr, logic expRegWr);
        vecS v;
        v = '{id, mb, wb, flush, expAlu, expExc, expWen, expBr, expRegWr};
        vectors.push_back(v);
        names.push_back(name);
    endtask

    task automatic addBranch(string name, branchE kind, logic [31:0] a, logic [31:0] b,
                             logic taken);
        idExeS id;
        id = baseRow(ALU_NOP, a, b);
        id.branch = kind;
        id.regWr = 1'b0;
        addRow(name, id, '0, '0, 1'b0, 32'h0, EXC_NONE, 4'b0000, taken, 1'b0);
    endtask

    task automatic buildTable();
        idExeS       id;
        aluOpE       opE;
        storeE       stE;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] m;
        logic [31:0] w;
        logic [3:0]  wen;
        logic        mis;
        for (int op = int'(ALU_ADD); op <= int'(ALU_LUI); op++) begin
            opE = aluOpE'(op);
            a = randWord();
            b = randWord();
            addRow(opE.name(), baseRow(opE, a, b), '0, '0, 1'b0, refAlu(opE, a, b),
                   refOverflow(opE, a, b) ? EXC_OVERFLOW : EXC_NONE, 4'b0000, 1'b0, 1'b1);
        end
        a = randWord();
        b = randWord();
        id = baseRow(ALU_ADDU, a, randWord());
        id.aluSrcB = 1'b1;      // imm32 replaces rt
        id.imm32 = b;
        addRow("ADDU imm", id, '0, '0, 1'b0, a + b, EXC_NONE, 4'b0000, 1'b0, 1'b1);
        id = baseRow(ALU_SRA, randWord(), b);
        id.aluSrcA = 1'b1;      // sa field replaces rs
        id.instr = randWord();
        addRow("SRA shamt", id, '0, '0, 1'b0, refAlu(ALU_SRA, {27'h0, id.instr[10:6]}, b),
               EXC_NONE, 4'b0000, 1'b0, 1'b1);
        addRow("ADD overflow", baseRow(ALU_ADD, 32'h7fffffff, 32'h1), '0, '0, 1'b0,
               32'h80000000, EXC_OVERFLOW, 4'b0000, 1'b0, 1'b1);
        addRow("ADDU no overflow", baseRow(ALU_ADDU, 32'h7fffffff, 32'h1), '0, '0, 1'b0,
               32'h80000000, EXC_NONE, 4'b0000, 1'b0, 1'b1);
        addRow("SUB overflow", baseRow(ALU_SUB, 32'h80000000, 32'h1), '0, '0, 1'b0,
               32'h7fffffff, EXC_OVERFLOW, 4'b0000, 1'b0, 1'b1);
        addRow("SUBU no overflow", baseRow(ALU_SUBU, 32'h80000000, 32'h1), '0, '0, 1'b0,
               32'h7fffffff, EXC_NONE, 4'b0000, 1'b0, 1'b1);

        m = randWord();
        w = randWord();
        id = baseRow(ALU_ADDU, a, b);
        id.rs = 5'd5;
        addRow("bypass mem over wb", id, {1'b1, 5'd5, m}, {1'b1, 5'd5, w}, 1'b0, m + b,
               EXC_NONE, 4'b0000, 1'b0, 1'b1);
        addRow("bypass wb only", id, {1'b1, 5'd7, m}, {1'b1, 5'd5, w}, 1'b0, w + b,
               EXC_NONE, 4'b0000, 1'b0, 1'b1);
        addRow("bypass regWr low", id, {1'b0, 5'd5, m}, '0, 1'b0, a + b,
               EXC_NONE, 4'b0000, 1'b0, 1'b1);
        addRow("bypass mem on rt", baseRow(ALU_ADDU, a, b), {1'b1, 5'd2, m}, '0, 1'b0, a + m,
               EXC_NONE, 4'b0000, 1'b0, 1'b1);
        id.rs = 5'd0;
        addRow("bypass reg zero", id, {1'b1, 5'd0, m}, '0, 1'b0, a + b,
               EXC_NONE, 4'b0000, 1'b0, 1'b1);
        id = baseRow(ALU_ADDU, a, b);
        id.readsRt = 1'b0;
        addRow("bypass unread rt", id, '0, {1'b1, 5'd2, w}, 1'b0, a + b,
               EXC_NONE, 4'b0000, 1'b0, 1'b1);

        addBranch("BEQ equal", BR_BEQ, 32'h5, 32'h5, 1'b1);
        addBranch("BEQ differ", BR_BEQ, 32'h5, 32'h6, 1'b0);
        addBranch("BNE differ", BR_BNE, 32'h5, 32'h6, 1'b1);
        addBranch("BNE equal", BR_BNE, 32'h5, 32'h5, 1'b0);
        addBranch("BGEZ zero", BR_BGEZ, 32'h0, 32'h1, 1'b1);
        addBranch("BGEZ negative", BR_BGEZ, 32'hffffffff, 32'h1, 1'b0);
        addBranch("BGTZ zero", BR_BGTZ, 32'h0, 32'h1, 1'b0);
        addBranch("BGTZ positive", BR_BGTZ, 32'h7, 32'h1, 1'b1);
        addBranch("BLEZ zero", BR_BLEZ, 32'h0, 32'h1, 1'b1);
        addBranch("BLEZ positive", BR_BLEZ, 32'h7, 32'h1, 1'b0);
        addBranch("BLTZ negative", BR_BLTZ, 32'h80000000, 32'h1, 1'b1);
        addBranch("BLTZ zero", BR_BLTZ, 32'h0, 32'h1, 1'b0);

        for (int s = int'(ST_SB); s <= int'(ST_SW); s++) begin
            for (int off = 0; off < 4; off++) begin
                stE = storeE'(s);
                a = randWord();
                a[1:0] = 2'b00;
                id = baseRow(ALU_ADDU, a, randWord());
                id.aluSrcB = 1'b1;
                id.imm32 = 32'(off);
                id.store = stE;
                id.regWr = 1'b0;
                wen = 4'b0000;
                case (stE)
                    ST_SB:   wen[off] = 1'b1;
                    ST_SH:   wen = (off >= 2) ? 4'b1100 : 4'b0011;
                    default: wen = 4'b1111;
                endcase
                mis = (stE == ST_SH && off % 2 == 1) || (stE == ST_SW && off != 0);
                addRow($sformatf("%s offset %0d", stE.name(), off), id, '0, '0, 1'b0,
                       a + 32'(off), mis ? EXC_ADDR_STORE : EXC_NONE,
                       mis ? 4'b0000 : wen, 1'b0, 1'b0);
            end
        end
        for (int off = 0; off < 4; off++) begin
            id = baseRow(ALU_ADDU, 32'h1000, 32'h0);
            id.aluSrcB = 1'b1;
            id.imm32 = 32'(off);
            id.dstSel = DST_RT;
            id.readsRt = 1'b0;
            id.load = LD_LW;
            addRow($sformatf("LW offset %0d", off), id, '0, '0, 1'b0, 32'h1000 + 32'(off),
                   (off != 0) ? EXC_ADDR_LOAD : EXC_NONE, 4'b0000, 1'b0, 1'b1);
            id.load = LD_LH;
            addRow($sformatf("LH offset %0d", off), id, '0, '0, 1'b0, 32'h1000 + 32'(off),
                   (off % 2 == 1) ? EXC_ADDR_LOAD : EXC_NONE, 4'b0000, 1'b0, 1'b1);
        end

        // overflowing store that already carries a syscall
        id = baseRow(ALU_ADD, 32'h7fffffff, 32'h1);
        id.except = EXC_SYSCALL;
        id.store = ST_SW;
        addRow("flush bubble", id, '0, '0, 1'b1, 32'h0, EXC_NONE, 4'b0000, 1'b0, 1'b0);
        addRow("syscall kept", id, '0, '0, 1'b0, 32'h80000000, EXC_SYSCALL, 4'b0000,
               1'b0, 1'b1);
    endtask

    task automatic runMd(string name, aluOpE op, logic [31:0] a, logic [31:0] b);
        logic [63:0] exp;
        int          stallCnt;
        int          guard;
        exp = refMd(op, a, b);
        @(negedge clk);
        idExe = baseRow(op, a, b);
        memBypass = '0;
        wbBypass = '0;
        exeWr = 1'b1;
        @(negedge clk);
        checkEq({name, " stall at start"}, 32'h1, 32'(mdStall));
        exeWr = 1'b0;   // op stays in the stage register
        stallCnt = 0;
        guard = 0;
        do begin
            @(negedge clk);
            guard++;
            if (mdStall)
                stallCnt++;
        end while (!mdFinish && guard < 4 * `MD_ITERS);
        if (!mdFinish)
            stopRun($sformatf("timeout waiting for mdFinish in %s", name));
        checkEq({name, " stall cycles"}, `MD_ITERS, stallCnt);
        checkEq({name, " hi"}, exp[63:32], mdHi);
        checkEq({name, " lo"}, exp[31:0], mdLo);
        exeFlush = 1'b1;    // retire the op on the finish edge
        @(negedge clk);
        checkEq({name, " single finish"}, 32'h0, 32'(mdFinish));
        checkEq({name, " idle after finish"}, 32'h0, 32'(mdStall));
        exeFlush = 1'b0;
    endtask

    task automatic abortMd(string name, aluOpE op, logic [31:0] a, logic [31:0] b);
        @(negedge clk);
        idExe = baseRow(op, a, b);
        memBypass = '0;
        wbBypass = '0;
        exeWr = 1'b1;
        @(negedge clk);
        exeWr = 1'b0;
        repeat (5) @(negedge clk);
        checkEq({name, " busy"}, 32'h1, 32'(mdStall));
        hiLoFlush = 1'b1;
        exeFlush = 1'b1;    // op leaves with the abort
        @(negedge clk);
        checkEq({name, " stall dropped"}, 32'h0, 32'(mdStall));
        hiLoFlush = 1'b0;
        exeFlush = 1'b0;
        for (int guard = 0; guard < 2 * `MD_ITERS; guard++) begin
            @(negedge clk);
            checkEq({name, " no finish"}, 32'h0, 32'(mdFinish));
            checkEq({name, " stays idle"}, 32'h0, 32'(mdStall));
        end
    endtask

    initial begin
        vecS v;
        rstN = 1'b0;
        exeWr = 1'b0;
        exeFlush = 1'b0;
        hiLoFlush = 1'b0;
        idExe = '0;
        memBypass = '0;
        wbBypass = '0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkEq("reset mdStall", 32'h0, 32'(mdStall));
        checkEq("reset mdFinish", 32'h0, 32'(mdFinish));
        checkEq("reset branchFlush", 32'h0, 32'(branchFlush));
        checkEq("reset dcacheWen", 32'h0, 32'(exeMem.dcacheWen));
        checkEq("reset regWr", 32'h0, 32'(exeMem.regWr));

        buildTable();
        for (int i = 0; i < vectors.size(); i++) begin
            v = vectors[i];
            @(negedge clk);
            idExe = v.id;
            memBypass = v.mb;
            wbBypass = v.wb;
            exeFlush = v.flush;
            exeWr = 1'b1;
            @(negedge clk);
            checkEq({names[i], " aluOut"}, v.expAlu, exeMem.aluOut);
            checkEq({names[i], " except"}, 32'(v.expExc), 32'(exeMem.except));
            checkEq({names[i], " dcacheWen"}, 32'(v.expWen), 32'(exeMem.dcacheWen));
            checkEq({names[i], " branchFlush"}, 32'(v.expBr), 32'(branchFlush));
            checkEq({names[i], " regWr"}, 32'(v.expRegWr), 32'(exeMem.regWr));
            checkEq({names[i], " load"}, v.flush ? 32'(LD_NONE) : 32'(v.id.load),
                    32'(exeMem.load));
            checkEq({names[i], " store"}, v.flush ? 32'(ST_NONE) : 32'(v.id.store),
                    32'(exeMem.store));
            if (!v.flush) begin    // a bubble keeps the old payload
                checkEq({names[i], " storeData"}, refStoreData(v), exeMem.storeData);
                checkEq({names[i], " dst"}, 32'(refDst(v.id)), 32'(exeMem.dst));
                checkEq({names[i], " pc"}, v.id.pc, exeMem.pc);
            end
            exeWr = 1'b0;
            exeFlush = 1'b0;
        end

        runMd("MULT", ALU_MULT, randWord(), randWord());
        runMd("MULTU", ALU_MULTU, randWord(), randWord());
        runMd("DIV", ALU_DIV, randWord(), randWord());
        runMd("DIVU", ALU_DIVU, randWord(), randWord());
        runMd("DIV by zero", ALU_DIV, randWord(), 32'h0);
        runMd("DIVU by zero", ALU_DIVU, randWord(), 32'h0);
        abortMd("MULT abort", ALU_MULT, randWord(), randWord());

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== hdl/exeTop.sv ====
// EXE stage only; hi/lo registers live outside so mdHi/mdLo are meaningful during mdFinish
`include "exe_config.svh"

module exeTop import isaPkg::*, pipePkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               exeWr,
    input  logic               exeFlush,
    input  logic               hiLoFlush,
    input  idExeS              idExe,
    input  bypassS             memBypass,
    input  bypassS             wbBypass,
    output exeMemS             exeMem,
    output logic               branchFlush,
    output logic               mdStall,
    output logic               mdFinish,
    output logic [`DATA_W-1:0] mdHi,
    output logic [`DATA_W-1:0] mdLo
);

    idExeS                 stage;
    logic [`REG_IDX_W-1:0] dst;
    logic [4:0]            shamt;
    logic [`DATA_W-1:0]    opA;
    logic [`DATA_W-1:0]    opB;
    logic [`DATA_W-1:0]    srcA;
    logic [`DATA_W-1:0]    srcB;
    logic [`DATA_W-1:0]    aluOut;
    exceptE                aluExcept;

    exeStageReg exeStageReg_u (
        .clk      (clk),
        .rstN     (rstN),
        .exeWr    (exeWr),
        .exeFlush (exeFlush),
        .idExe    (idExe),
        .stage    (stage),
        .dst      (dst),
        .shamt    (shamt)
    );

    operandBypass operandBypass_u (
        .stage     (stage),
        .memBypass (memBypass),
        .wbBypass  (wbBypass),
        .opA       (opA),
        .opB       (opB)
    );

    // second-level select after bypass
    assign srcA = stage.aluSrcA ? {{(`DATA_W-5){1'b0}}, shamt} : opA;
    assign srcB = stage.aluSrcB ? stage.imm32 : opB;

    aluCore aluCore_u (
        .aluOp     (stage.aluOp),
        .srcA      (srcA),
        .srcB      (srcB),
        .exceptIn  (stage.except),
        .aluOut    (aluOut),
        .exceptOut (aluExcept)
    );

    multDivUnit multDivUnit_u (
        .clk       (clk),
        .rstN      (rstN),
        .aluOp     (stage.aluOp),
        .opA       (opA),
        .opB       (opB),
        .hiLoFlush (hiLoFlush),
        .stall     (mdStall),
        .finish    (mdFinish),
        .hi        (mdHi),
        .lo        (mdLo)
    );

    exeResult exeResult_u (
        .stage       (stage),
        .opA         (opA),
        .opB         (opB),
        .aluOut      (aluOut),
        .aluExcept   (aluExcept),
        .dst         (dst),
        .exeMem      (exeMem),
        .branchFlush (branchFlush)
    );

endmodule

// ==== execute/exeResult.sv ====
// branch target redirect is left to fetch; this only raises the flush level and packs exeMem
`include "exe_config.svh"

module exeResult import isaPkg::*, pipePkg::*; (
    input  idExeS                 stage,
    input  logic [`DATA_W-1:0]    opA,
    input  logic [`DATA_W-1:0]    opB,
    input  logic [`DATA_W-1:0]    aluOut,
    input  exceptE                aluExcept,
    input  logic [`REG_IDX_W-1:0] dst,
    output exeMemS                exeMem,
    output logic                  branchFlush
);

    logic       aNeg;
    logic       aZero;
    logic       loadMis;
    logic       storeMis;
    logic [3:0] wen;
    exceptE     exceptFinal;

    assign aNeg  = opA[`DATA_W-1];
    assign aZero = (opA == '0);

    always_comb begin
        case (stage.branch)
            BR_BEQ:  branchFlush = (opA == opB);
            BR_BNE:  branchFlush = (opA != opB);
            BR_BGEZ: branchFlush = !aNeg;
            BR_BGTZ: branchFlush = !aNeg && !aZero;
            BR_BLEZ: branchFlush = aNeg || aZero;
            BR_BLTZ: branchFlush = aNeg;
            default: branchFlush = 1'b0;
        endcase
    end

    always_comb begin
        case (stage.store)
            ST_SB:   wen = 4'b0001 << aluOut[1:0];
            ST_SH:   wen = aluOut[1] ? 4'b1100 : 4'b0011;
            ST_SW:   wen = 4'b1111;
            default: wen = 4'b0000;
        endcase
    end

    // halfword needs bit 0 clear, word needs both low bits clear
    assign loadMis  = ((stage.load == LD_LH || stage.load == LD_LHU) && aluOut[0])
                      || (stage.load == LD_LW && aluOut[1:0] != 2'b00);
    assign storeMis = (stage.store == ST_SH && aluOut[0])
                      || (stage.store == ST_SW && aluOut[1:0] != 2'b00);

    always_comb begin
        if (aluExcept != EXC_NONE)
            exceptFinal = aluExcept;
        else if (loadMis)
            exceptFinal = EXC_ADDR_LOAD;
        else if (storeMis)
            exceptFinal = EXC_ADDR_STORE;
        else
            exceptFinal = EXC_NONE;
    end

    always_comb begin
        exeMem.aluOut    = aluOut;
        exeMem.storeData = opB;          // bypassed rt
        exeMem.dst       = dst;
        exeMem.pc        = stage.pc;
        exeMem.load      = stage.load;
        exeMem.store     = stage.store;
        exeMem.regWr     = stage.regWr;
        exeMem.except    = exceptFinal;
        exeMem.dcacheWen = (exceptFinal != EXC_NONE) ? 4'b0000 : wen;   // no write on trap
    end

endmodule

// ==== execute/multDivUnit.sv ====
// one bit per cycle mult/div; the op must stay in the stage register until finish or abort
`include "exe_config.svh"

module multDivUnit import isaPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  aluOpE              aluOp,
    input  logic [`DATA_W-1:0] opA,
    input  logic [`DATA_W-1:0] opB,
    input  logic               hiLoFlush,
    output logic               stall,
    output logic               finish,
    output logic [`DATA_W-1:0] hi,
    output logic [`DATA_W-1:0] lo
);

    localparam int cntWidth = $clog2(`MD_ITERS);

    typedef enum logic [1:0] {IDLE, BUSY, DONE} mdStateE;

    mdStateE               state;
    logic [cntWidth-1:0]   iterCnt;
    logic [2*`DATA_W-1:0]  acc;       // {hi, lo} working pair
    logic [`DATA_W-1:0]    operand;   // multiplicand or divisor magnitude
    logic                  isDiv;
    logic                  negQ;      // negate product or quotient
    logic                  negR;      // remainder follows dividend sign
    logic                  divZero;
    logic                  isMdOp;
    logic                  isDivOp;
    logic                  isSigned;
    logic [`DATA_W-1:0]    magA;
    logic [`DATA_W-1:0]    magB;
    logic [`DATA_W:0]      addSum;
    logic [`DATA_W:0]      shifted;
    logic [`DATA_W:0]      trial;
    logic [2*`DATA_W-1:0]  mulNext;
    logic [2*`DATA_W-1:0]  divNext;

    assign isMdOp   = aluOp inside {ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU};
    assign isDivOp  = aluOp inside {ALU_DIV, ALU_DIVU};
    assign isSigned = aluOp inside {ALU_MULT, ALU_DIV};

    assign magA = (isSigned && opA[`DATA_W-1]) ? -opA : opA;
    assign magB = (isSigned && opB[`DATA_W-1]) ? -opB : opB;

    // shift-add, multiplier bits leave from the bottom of lo
    assign addSum  = {1'b0, acc[2*`DATA_W-1:`DATA_W]}
                     + (acc[0] ? {1'b0, operand} : {(`DATA_W+1){1'b0}});
    assign mulNext = {addSum, acc[`DATA_W-1:1]};

    // restoring divide, quotient bits enter at the bottom of lo
    assign shifted = acc[2*`DATA_W-1:`DATA_W-1];
    assign trial   = shifted - {1'b0, operand};
    assign divNext = trial[`DATA_W] ? {shifted[`DATA_W-1:0], acc[`DATA_W-2:0], 1'b0}
                                    : {trial[`DATA_W-1:0], acc[`DATA_W-2:0], 1'b1};

    always_ff @(posedge clk) begin
        if (!rstN || hiLoFlush) begin   // abort drops back without a finish pulse
            state   <= IDLE;
            iterCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    iterCnt <= '0;
                    if (isMdOp)
                        state <= BUSY;
                end
                BUSY: begin
                    iterCnt <= iterCnt + 1'b1;
                    if (iterCnt == cntWidth'(`MD_ITERS - 1))
                        state <= DONE;
                end
                default: state <= IDLE;   // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            isDiv   <= isDivOp;
            negQ    <= isSigned && (opA[`DATA_W-1] ^ opB[`DATA_W-1]);
            negR    <= isSigned && opA[`DATA_W-1];
            divZero <= (opB == '0);
            acc     <= {{`DATA_W{1'b0}}, (isDivOp ? magA : magB)};
            operand <= isDivOp ? magB : magA;
        end else if (state == BUSY) begin
            acc <= isDiv ? divNext : mulNext;
        end
    end

    assign stall  = (state == IDLE && isMdOp && !hiLoFlush) || state == BUSY;
    assign finish = (state == DONE);

    // sign restore, valid while finish is high
    always_comb begin
        if (!isDiv) begin
            {hi, lo} = negQ ? -acc : acc;
        end else if (divZero) begin
            hi = '0;
            lo = '0;
        end else begin
            lo = negQ ? -acc[`DATA_W-1:0] : acc[`DATA_W-1:0];
            hi = negR ? -acc[2*`DATA_W-1:`DATA_W] : acc[2*`DATA_W-1:`DATA_W];
        end
    end

endmodule

// ==== execute/aluCore.sv ====
// single-cycle ALU; mult/div opcodes yield zero here, shifts take the amount from srcA[4:0]
`include "exe_config.svh"

module aluCore import isaPkg::*; (
    input  aluOpE              aluOp,
    input  logic [`DATA_W-1:0] srcA,
    input  logic [`DATA_W-1:0] srcB,
    input  exceptE             exceptIn,
    output logic [`DATA_W-1:0] aluOut,
    output exceptE             exceptOut
);

    logic [`DATA_W-1:0] sum;
    logic [`DATA_W-1:0] diff;
    logic               overflow;

    assign sum  = srcA + srcB;
    assign diff = srcA - srcB;

    always_comb begin
        overflow = 1'b0;
        case (aluOp)
            ALU_ADD: begin
                aluOut   = sum;
                // same input signs, result sign flipped
                overflow = (srcA[`DATA_W-1] == srcB[`DATA_W-1])
                           && (sum[`DATA_W-1] != srcA[`DATA_W-1]);
            end
            ALU_ADDU: aluOut = sum;
            ALU_SUB: begin
                aluOut   = diff;
                overflow = (srcA[`DATA_W-1] != srcB[`DATA_W-1])
                           && (diff[`DATA_W-1] != srcA[`DATA_W-1]);
            end
            ALU_SUBU: aluOut = diff;
            ALU_AND:  aluOut = srcA & srcB;
            ALU_OR:   aluOut = srcA | srcB;
            ALU_XOR:  aluOut = srcA ^ srcB;
            ALU_NOR:  aluOut = ~(srcA | srcB);
            ALU_SLT:  aluOut = {{(`DATA_W-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_SLTU: aluOut = {{(`DATA_W-1){1'b0}}, srcA < srcB};
            ALU_SLL:  aluOut = srcB << srcA[4:0];
            ALU_SRL:  aluOut = srcB >> srcA[4:0];
            ALU_SRA:  aluOut = $signed(srcB) >>> srcA[4:0];
            ALU_LUI:  aluOut = srcB << 16;
            default:  aluOut = '0;   // nop and the multi-cycle ops
        endcase
    end

    // an exception from decode takes precedence
    assign exceptOut = (overflow && exceptIn == EXC_NONE) ? EXC_OVERFLOW : exceptIn;

endmodule

// ==== execute/operandBypass.sv ====
// first-level operand select; MEM is newer than WB so it wins, and gpr 0 never bypasses
`include "exe_config.svh"

module operandBypass import pipePkg::*; (
    input  idExeS              stage,
    input  bypassS             memBypass,
    input  bypassS             wbBypass,
    output logic [`DATA_W-1:0] opA,
    output logic [`DATA_W-1:0] opB
);

    logic memHitA;
    logic memHitB;
    logic wbHitA;
    logic wbHitB;

    // unused source fields may hold stale indices, so gate on the read flags
    assign memHitA = stage.readsRs && memBypass.regWr && memBypass.dst == stage.rs
                     && stage.rs != '0;
    assign memHitB = stage.readsRt && memBypass.regWr && memBypass.dst == stage.rt
                     && stage.rt != '0;
    assign wbHitA  = stage.readsRs && wbBypass.regWr && wbBypass.dst == stage.rs
                     && stage.rs != '0;
    assign wbHitB  = stage.readsRt && wbBypass.regWr && wbBypass.dst == stage.rt
                     && stage.rt != '0;

    always_comb begin
        if (memHitA)
            opA = memBypass.result;
        else if (wbHitA)
            opA = wbBypass.result;
        else
            opA = stage.busA;

        if (memHitB)
            opB = memBypass.result;
        else if (wbHitB)
            opB = wbBypass.result;
        else
            opB = stage.busB;
    end

endmodule

// ==== execute/exeStageReg.sv ====
// ID/EXE register; flush wins over exeWr and a bubble only clears the control fields
`include "exe_config.svh"

module exeStageReg import isaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  exeWr,
    input  logic                  exeFlush,
    input  idExeS                 idExe,
    output idExeS                 stage,
    output logic [`REG_IDX_W-1:0] dst,
    output logic [4:0]            shamt
);

    always_ff @(posedge clk) begin
        if (!rstN || exeFlush) begin
            // bubble, payload fields keep whatever they held
            stage.aluOp  <= ALU_NOP;
            stage.regWr  <= 1'b0;
            stage.load   <= LD_NONE;
            stage.store  <= ST_NONE;
            stage.branch <= BR_NONE;
            stage.except <= EXC_NONE;
        end else if (exeWr) begin
            stage <= idExe;
        end
    end

    // write destination
    always_comb begin
        case (stage.dstSel)
            DST_RD:  dst = stage.rd;
            DST_RT:  dst = stage.rt;            // immediate and load forms
            DST_RA:  dst = `REG_IDX_W'd31;      // link
            default: dst = stage.rd;
        endcase
    end

    assign shamt = stage.instr[10:6];   // sa field of R-type shifts

endmodule

// ==== common/pipePkg.sv ====
// stage bundles only; field order is fixed so neighbouring stages must be rebuilt together
`include "exe_config.svh"

package pipePkg;
    import isaPkg::*;

    typedef struct packed {
        logic [`DATA_W-1:0]    busA;     // register file read of rs
        logic [`DATA_W-1:0]    busB;     // register file read of rt
        logic [`DATA_W-1:0]    imm32;
        logic [`DATA_W-1:0]    pc;
        logic [`DATA_W-1:0]    instr;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] rd;
        aluOpE                 aluOp;
        dstSelE                dstSel;
        logic                  aluSrcA;  // take shamt instead of rs
        logic                  aluSrcB;  // take imm32 instead of rt
        logic                  readsRs;
        logic                  readsRt;
        loadE                  load;
        storeE                 store;
        branchE                branch;
        logic                  regWr;
        exceptE                except;
    } idExeS;

    // writeback of one later stage as EXE sees it
    typedef struct packed {
        logic                  regWr;
        logic [`REG_IDX_W-1:0] dst;
        logic [`DATA_W-1:0]    result;
    } bypassS;

    typedef struct packed {
        logic [`DATA_W-1:0]    aluOut;
        logic [`DATA_W-1:0]    storeData;
        logic [`REG_IDX_W-1:0] dst;
        logic [`DATA_W-1:0]    pc;
        loadE                  load;
        storeE                 store;
        logic                  regWr;
        exceptE                except;     // final, after alu and address checks
        logic [3:0]            dcacheWen;  // one bit per byte lane
    } exeMemS;

endpackage

// ==== common/isaPkg.sv ====
// instruction-level encodings seen by EXE; literals carry a prefix since NONE recurs across kinds
package isaPkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_MULT,   // multi-cycle ops go to multDivUnit
        ALU_MULTU,
        ALU_DIV,
        ALU_DIVU,
        ALU_NOP
    } aluOpE;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ
    } branchE;

    typedef enum logic [2:0] {
        LD_NONE, LD_LB, LD_LBU, LD_LH, LD_LHU, LD_LW
    } loadE;

    typedef enum logic [1:0] {ST_NONE, ST_SB, ST_SH, ST_SW} storeE;

    // syscall and reserved come from decode and only pass through
    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_OVERFLOW,
        EXC_ADDR_LOAD,
        EXC_ADDR_STORE,
        EXC_SYSCALL,
        EXC_RESERVED
    } exceptE;

    typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} dstSelE;   // ra is gpr 31

endpackage

// ==== common/exe_config.svh ====
// sizes are shared by every stage file; MD_ITERS must equal DATA_W for the iterative mult/div
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

`define DATA_W     32   // integer datapath width
`define REG_IDX_W  5    // gpr index width

// one quotient or product bit per cycle
`define MD_ITERS   32

`endif
